// File: verilog.f
+incdir+src
+incdir+dv
src/bus_pkg.sv
src/video_pkg.sv
src/vram.sv
src/palette_mem.sv
src/bus_regs.sv
src/video_timing_gen.sv
src/vid_main.sv
dv/tb_vid_main.sv

// File: Bender.yml
package:
  name: vid_main

sources:
  - include_dirs:
      - src
    files:
      - src/bus_pkg.sv
      - src/video_pkg.sv
      - src/vram.sv
      - src/palette_mem.sv
      - src/bus_regs.sv
      - src/video_timing_gen.sv
      - src/vid_main.sv
  - target: test
    include_dirs:
      - src
      - dv
    files:
      - dv/tb_vid_main.sv

// File: dv/tb_vid_tasks.svh
`ifndef TB_VID_TASKS_SVH
`define TB_VID_TASKS_SVH

// even byte first and the odd byte commits
task automatic bus_write(input logic [3:0] r, input logic [15:0] w);
    @(negedge clk);
    bus_cs_n_i    = 1'b0;
    bus_rd_nwr_i  = 1'b0;
    bus_reg_num_i = r;
    bus_bytesel_i = 1'b0;
    bus_data_i    = w[15:8];
    @(negedge clk);
    bus_bytesel_i = 1'b1;
    bus_data_i    = w[7:0];
    @(negedge clk);
    bus_cs_n_i   = 1'b1;
    bus_rd_nwr_i = 1'b1;
endtask

task automatic bus_read(input logic [3:0] r, output logic [15:0] w);
    @(negedge clk);
    bus_cs_n_i    = 1'b0;
    bus_rd_nwr_i  = 1'b1;
    bus_reg_num_i = r;
    bus_bytesel_i = 1'b0;
    #1 w[15:8] = bus_data_o;
    @(negedge clk);
    bus_bytesel_i = 1'b1;
    #1 w[7:0] = bus_data_o;
    @(negedge clk);
    bus_cs_n_i = 1'b1;
endtask

task automatic data_write(input logic [15:0] w);
    bus_write(DATA, w);
    repeat (3) @(negedge clk);      // vram request may wait on video
endtask

task automatic xr_write(input logic [15:0] a, input logic [15:0] d);
    bus_write(XR_ADDR, a);
    bus_write(XR_DATA, d);
endtask

task automatic xr_read(input logic [15:0] a, output logic [15:0] w);
    bus_write(XR_ADDR, a);
    repeat (3) @(negedge clk);      // register word lands in the read latch
    bus_read(XR_DATA, w);
endtask

task automatic count_strobes(input int cycles, output int n);
    n = 0;
    repeat (cycles) begin
        @(negedge clk);
        if (bus_intr_o) n++;
    end
endtask

task automatic wait_intr(input string what);
    int n;
    n = 0;
    while (!bus_intr_o && n < 2 * FRAME_CYCLES) begin
        @(negedge clk);
        n++;
    end
    assert (bus_intr_o) else begin
        errors++;
        $display("No interrupt strobe seen for %s within two frames", what);
    end
endtask

task automatic vram_write_readback();
    logic [15:0] words [8];
    logic [15:0] got;
    bus_write(SYS_CTRL, 16'h0F00);          // all nibbles writable
    bus_write(WR_INCR, 16'h0001);
    bus_write(WR_ADDR, 16'h0100);
    foreach (words[i]) begin
        words[i] = lcg_next();
        data_write(words[i]);
    end
    bus_write(RD_ADDR, 16'h0100);
    repeat (4) @(negedge clk);
    foreach (words[i]) begin
        bus_read(DATA, got);
        check_value("DATA readback", words[i], got);
        repeat (4) @(negedge clk);
    end
endtask

task automatic nibble_mask_write();
    logic [15:0] got;
    bus_write(WR_ADDR, 16'h0200);
    data_write(16'h1234);
    bus_write(SYS_CTRL, 16'h0500);          // nibbles 0 and 2 only
    bus_write(WR_ADDR, 16'h0200);
    data_write(16'hABCD);
    bus_write(SYS_CTRL, 16'h0F00);
    bus_write(RD_ADDR, 16'h0200);
    repeat (4) @(negedge clk);
    bus_read(DATA, got);
    check_value("masked DATA", 16'h1B3D, got);  // B and D new, 1 and 3 kept
endtask

task automatic palette_pixel_compare();
    logic [15:0] w;
    for (int i = 0; i < 16; i++) begin
        pal_model[i] = lcg_next();
        xr_write(16'h8000 | 16'(i), pal_model[i]);  // is_mem set with region palette
    end
    bus_write(WR_ADDR, 16'h0000);
    foreach (img_model[i]) begin
        w = lcg_next();
        img_model[i] = {w[15:8], 4'h0, w[3:0]};     // index into the written entries
        data_write(img_model[i]);
    end
    pix_check = 1'b1;
    repeat (FRAME_CYCLES) @(negedge clk);
    pix_check = 1'b0;
endtask

task automatic sync_geometry_count();
    int de_n;
    int hs_n;
    int vs_n;
    de_n = 0;
    hs_n = 0;
    vs_n = 0;
    repeat (FRAME_CYCLES) begin             // any full frame window
        @(negedge clk);
        de_n += dv_de_o;
        hs_n += hsync_o;
        vs_n += vsync_o;
    end
    check_value("dv_de_o cycles per frame", 16'd128, 16'(de_n));
    check_value("hsync_o cycles per frame", 16'd24, 16'(hs_n));
    check_value("vsync_o cycles per frame", 16'd48, 16'(vs_n));
endtask

task automatic interrupt_sources();
    logic [15:0] st;
    int          n;
    bus_write(SYS_CTRL, 16'h0F01);          // vblank only
    count_strobes(FRAME_CYCLES, n);
    check_value("bus_intr_o pulses per frame", 16'd1, 16'(n));
    wait_intr("vblank");
    xr_read({11'd0, INTR_STATUS}, st);
    check_value("INTR_STATUS bit 0 set", 16'h1, {15'd0, st[0]});
    bus_write(INTR_CLR, 16'h000F);
    xr_read({11'd0, INTR_STATUS}, st);
    check_value("INTR_STATUS bit 0 cleared", 16'h0, {15'd0, st[0]});
    bus_write(SYS_CTRL, 16'h0F00);          // everything masked
    xr_write({11'd0, INTR_RAISE}, 16'h0004);
    count_strobes(4, n);
    check_value("bus_intr_o pulses while masked", 16'd0, 16'(n));
    xr_read({11'd0, INTR_STATUS}, st);
    check_value("INTR_STATUS bit 2 set", 16'h1, {15'd0, st[2]});
    xr_write({11'd0, LINE_CMP}, 16'h0003);
    bus_write(SYS_CTRL, 16'h0F02);          // line compare only
    wait_intr("line compare");
    bus_write(SYS_CTRL, 16'h0F00);
endtask

task automatic vreg_readback();
    logic [15:0] got;
    xr_write({11'd0, DISP_BASE}, 16'h0123);
    xr_read({11'd0, DISP_BASE}, got);
    check_value("DISP_BASE", 16'h0123, got);
    xr_write({11'd0, DISP_BASE}, 16'h0000);
    xr_read({11'd0, LINE_CMP}, got);
    check_value("LINE_CMP", 16'h0003, got);
    repeat (3) begin
        xr_read({11'd0, SCANLINE}, got);
        assert (got < 16'd12) else begin
            errors++;
            $display("Mismatch at %0t: SCANLINE expected below 12, got %0d", $time, got);
        end
    end
endtask

`endif

// File: dv/tb_vid_main.sv
`timescale 1ns/1ps
`include "vid_defines.svh"

module tb_vid_main import bus_pkg::*, video_pkg::*; ();

    localparam int FRAME_CYCLES = `VID_H_TOTAL * `VID_V_TOTAL;
    localparam int NUM_TESTS    = 6;
    localparam int WD_CYCLES    = 4 * FRAME_CYCLES + NUM_TESTS * 200;

    logic       clk;
    logic       reset_i;
    logic       bus_cs_n_i;
    logic       bus_rd_nwr_i;
    logic [3:0] bus_reg_num_i;
    logic       bus_bytesel_i;
    logic [7:0] bus_data_i;
    logic [7:0] bus_data_o;
    logic       bus_intr_o;
    logic [3:0] red_o;
    logic [3:0] green_o;
    logic [3:0] blue_o;
    logic       hsync_o;
    logic       vsync_o;
    logic       dv_de_o;

    int          errors;
    logic [31:0] seed;
    logic [15:0] pal_model [256];   // what the cpu wrote to the palette
    logic [15:0] img_model [64];    // 8 x 8 word image at vram 0
    logic        pix_check;         // compare pixels only while image is stable
    int          pix_x;
    int          pix_y;
    logic        de_prev;
    logic        vs_prev;

    vid_main dut0 (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;     // 40 ns period
    end

    // lcg step returning upper state bits
    function automatic logic [15:0] lcg_next();
        seed = seed * 32'd1103515245 + 32'd12345;
        return seed[30:15];
    endfunction

    task automatic check_value(input string name, input logic [15:0] exp, input logic [15:0] got);
        assert (exp === got) else begin
            errors++;
            $display("Mismatch at %0t: %s expected %h, got %h", $time, name, exp, got);
        end
    endtask

    // pixel monitor sampling between edges
    always @(negedge clk) begin
        if (!reset_i) begin
            if (dv_de_o) begin
                if (pix_check && pix_y < 8) begin
                    check_value("rgb",
                                {4'h0, pal_model[img_model[pix_y*8 + pix_x/2][7:0]][11:0]},
                                {4'h0, red_o, green_o, blue_o});
                end
                pix_x++;
            end else begin
                check_value("rgb in blanking", 16'h0, {4'h0, red_o, green_o, blue_o});
                if (de_prev) begin              // end of a visible line
                    check_value("de cycles per line", 16'd16, 16'(pix_x));
                    pix_x = 0;
                    pix_y++;
                end
            end
            if (vsync_o && !vs_prev) pix_y = 0;  // new frame
            de_prev = dv_de_o;
            vs_prev = vsync_o;
        end
    end

    // watchdog sized from frame length and test count
    initial begin
        repeat (WD_CYCLES) @(posedge clk);
        $display("Timeout: the run hung and the tests did not finish");
        $display("Errors found");
        $finish;
    end

    `include "tb_vid_tasks.svh"

    initial begin
        errors        = 0;
        seed          = 32'd71;
        pix_check     = 1'b0;
        pix_x         = 0;
        pix_y         = 0;
        de_prev       = 1'b0;
        vs_prev       = 1'b0;
        reset_i       = 1'b1;
        bus_cs_n_i    = 1'b1;
        bus_rd_nwr_i  = 1'b1;
        bus_reg_num_i = 4'h0;
        bus_bytesel_i = 1'b0;
        bus_data_i    = 8'h00;
        repeat (4) @(negedge clk);
        reset_i = 1'b0;
        @(negedge clk);
        vram_write_readback();
        nibble_mask_write();
        palette_pixel_compare();
        sync_geometry_count();
        interrupt_sources();
        vreg_readback();
        $display("checks done, %0d errors", errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

// File: src/vid_main.sv
`timescale 1ns/1ps
`include "vid_defines.svh"

module vid_main import bus_pkg::*, video_pkg::*; (
    input  logic       clk,
    input  logic       reset_i,
    input  logic       bus_cs_n_i,
    input  logic       bus_rd_nwr_i,
    input  logic [3:0] bus_reg_num_i,
    input  logic       bus_bytesel_i,
    input  logic [7:0] bus_data_i,
    output logic [7:0] bus_data_o,
    output logic       bus_intr_o,       // strobe
    output logic [3:0] red_o,
    output logic [3:0] green_o,
    output logic [3:0] blue_o,
    output logic       hsync_o,
    output logic       vsync_o,
    output logic       dv_de_o
);

    mem_req_t                  cpu_req;
    logic                      fetch_sel;       // video owns vram
    logic [15:0]               fetch_addr;
    logic [15:0]               fetch_data;
    logic                      vram_sel;
    logic                      vram_wr;
    logic [11:0]               vram_addr;
    logic [15:0]               vram_rdata;
    logic                      vgen_load;       // video word on vram output now
    logic [15:0]               vgen_word;       // kept for the second pixel
    logic                      cpu_load;
    xr_addr_u                  xr_addr;
    logic                      vreg_wr;
    logic                      pal_wr;
    logic [15:0]               vreg_rdata;
    logic [15:0]               xr_rdata;
    logic [`VID_INTR_BITS-1:0] intr_mask;
    logic [`VID_INTR_BITS-1:0] intr_clear;
    logic [`VID_INTR_BITS-1:0] intr_signal;
    logic [`VID_INTR_BITS-1:0] intr_status;
    logic [7:0]                color_index;
    logic [15:0]               pal_rdata;
    pixel_t                    vgen_timing;
    pixel_t                    timing_d;        // waits out the palette read
    pixel_t                    pix_q;

    // video fetch wins, cpu request waits for a gap
    assign vram_sel   = fetch_sel | cpu_req.vram_sel;
    assign vram_wr    = ~fetch_sel & cpu_req.vram_sel & cpu_req.wr;
    assign vram_addr  = fetch_sel ? fetch_addr[11:0] : cpu_req.addr[11:0];
    assign fetch_data = vgen_load ? vram_rdata : vgen_word;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            vgen_load <= 1'b0;
            cpu_load  <= 1'b0;
        end else begin
            vgen_load <= fetch_sel;
            cpu_load  <= cpu_req.vram_sel & ~fetch_sel & ~cpu_req.wr;    // taken read
        end
    end

    always_ff @(posedge clk) begin
        if (vgen_load) begin
            vgen_word <= vram_rdata;
        end
    end

    // xr word: register number, or region plus offset
    assign xr_addr = cpu_req.addr;
    assign vreg_wr = cpu_req.xr_sel & cpu_req.wr & ~xr_addr.r.is_mem;
    assign pal_wr  = cpu_req.xr_sel & cpu_req.wr & xr_addr.m.is_mem
                   & (xr_addr.m.region == PALETTE);

    always_ff @(posedge clk) begin
        if (cpu_req.xr_sel) begin
            xr_rdata <= xr_addr.r.is_mem ? 16'h0000 : vreg_rdata;  // memories read zero
        end
    end

    bus_regs u_bus_regs (
        .clk           (clk),
        .reset_i       (reset_i),
        .bus_cs_n_i    (bus_cs_n_i),
        .bus_rd_nwr_i  (bus_rd_nwr_i),
        .bus_reg_num_i (bus_reg_num_i),
        .bus_bytesel_i (bus_bytesel_i),
        .bus_data_i    (bus_data_i),
        .bus_data_o    (bus_data_o),
        .vgen_sel_i    (fetch_sel),
        .req_o         (cpu_req),
        .intr_mask_o   (intr_mask),
        .intr_clear_o  (intr_clear),
        .rdata_i       (vram_rdata),
        .rdata_valid_i (cpu_load),
        .xr_rdata_i    (xr_rdata)
    );

    video_timing_gen u_video_timing_gen (
        .clk           (clk),
        .reset_i       (reset_i),
        .reg_wr_i      (vreg_wr),
        .reg_num_i     (vreg_e'(xr_addr.r.reg_num)),
        .reg_data_i    (cpu_req.wdata),
        .reg_data_o    (vreg_rdata),
        .intr_status_i (intr_status),
        .intr_signal_o (intr_signal),
        .fetch_sel_o   (fetch_sel),
        .fetch_addr_o  (fetch_addr),
        .fetch_data_i  (fetch_data),
        .color_index_o (color_index),
        .timing_o      (vgen_timing)
    );

    vram u_vram (
        .clk     (clk),
        .sel_i   (vram_sel),
        .wr_i    (vram_wr),
        .mask_i  (cpu_req.mask),
        .addr_i  (vram_addr),
        .wdata_i (cpu_req.wdata),
        .rdata_o (vram_rdata)
    );

    palette_mem u_palette_mem (
        .clk       (clk),
        .wr_i      (pal_wr),
        .wr_addr_i (xr_addr.m.offset[7:0]),
        .wr_data_i (cpu_req.wdata),
        .rd_addr_i (color_index),
        .rd_data_o (pal_rdata)
    );

    // sync and enable share the output register with the colour
    always_ff @(posedge clk) begin
        if (reset_i) begin
            timing_d <= '0;
            pix_q    <= '0;
        end else begin
            timing_d    <= vgen_timing;
            pix_q.hsync <= timing_d.hsync;
            pix_q.vsync <= timing_d.vsync;
            pix_q.de    <= timing_d.de;
            pix_q.rgb   <= timing_d.de ? pal_rdata[11:0] : 12'h000;  // black in blanking
        end
    end

    assign hsync_o                   = pix_q.hsync;
    assign vsync_o                   = pix_q.vsync;
    assign dv_de_o                   = pix_q.de;
    assign {red_o, green_o, blue_o}  = pix_q.rgb;

    // status remembers every source, strobe only for unmasked ones
    always_ff @(posedge clk) begin
        if (reset_i) begin
            intr_status <= '0;
            bus_intr_o  <= 1'b0;
        end else begin
            intr_status <= (intr_status | intr_signal) & ~intr_clear;
            bus_intr_o  <= |(intr_signal & intr_mask);
        end
    end

endmodule

// File: src/video_timing_gen.sv
`timescale 1ns/1ps
`include "vid_defines.svh"

module video_timing_gen import video_pkg::*; (
    input  logic                      clk,
    input  logic                      reset_i,
    input  logic                      reg_wr_i,
    input  vreg_e                     reg_num_i,
    input  logic [15:0]               reg_data_i,
    output logic [15:0]               reg_data_o,
    input  logic [`VID_INTR_BITS-1:0] intr_status_i,
    output logic [`VID_INTR_BITS-1:0] intr_signal_o,  // pulses
    output logic                      fetch_sel_o,
    output logic [15:0]               fetch_addr_o,
    input  logic [15:0]               fetch_data_i,   // word one cycle after fetch
    output logic [7:0]                color_index_o,
    output pixel_t                    timing_o        // rgb left zero
);

    logic [4:0]  h_cnt;
    logic [3:0]  v_cnt;
    logic [15:0] disp_base;
    logic [15:0] line_cmp;
    logic        h_vis;
    logic        v_vis;

    assign h_vis = h_cnt < 5'(`VID_H_VISIBLE);
    assign v_vis = v_cnt < 4'(`VID_V_VISIBLE);

    // one word per pixel pair, 8 words per line
    assign fetch_sel_o   = h_vis & v_vis & ~h_cnt[0];
    assign fetch_addr_o  = disp_base + {10'b0, v_cnt[2:0], h_cnt[3:1]};
    assign color_index_o = fetch_data_i[7:0];   // low byte is palette index

    always_ff @(posedge clk) begin
        if (reset_i) begin
            h_cnt <= '0;
            v_cnt <= '0;
        end else if (h_cnt == 5'(`VID_H_TOTAL - 1)) begin
            h_cnt <= '0;
            v_cnt <= (v_cnt == 4'(`VID_V_TOTAL - 1)) ? '0 : v_cnt + 1'b1;
        end else begin
            h_cnt <= h_cnt + 1'b1;
        end
    end

    // delayed one clock to line up with the fetched word
    always_ff @(posedge clk) begin
        if (reset_i) begin
            timing_o <= '0;
        end else begin
            timing_o.hsync <= h_cnt >= 5'(`VID_H_SYNC_START) && h_cnt < 5'(`VID_H_SYNC_END);
            timing_o.vsync <= v_cnt >= 4'(`VID_V_SYNC_START) && v_cnt < 4'(`VID_V_SYNC_END);
            timing_o.de    <= h_vis & v_vis;
            timing_o.rgb   <= '0;
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            disp_base     <= '0;
            line_cmp      <= '0;
            intr_signal_o <= '0;
        end else begin
            intr_signal_o[0]   <= h_cnt == '0 && v_cnt == 4'(`VID_V_VISIBLE);  // vblank
            intr_signal_o[1]   <= h_cnt == '0 && line_cmp == {12'b0, v_cnt};
            intr_signal_o[3:2] <= 2'b00;
            if (reg_wr_i) begin
                case (reg_num_i)
                    DISP_BASE:  disp_base <= reg_data_i;
                    LINE_CMP:   line_cmp <= reg_data_i;
                    INTR_RAISE: intr_signal_o[3:2] <= reg_data_i[3:2];
                    default: ;                          // read only regs
                endcase
            end
        end
    end

    always_comb begin
        case (reg_num_i)
            DISP_BASE:   reg_data_o = disp_base;
            LINE_CMP:    reg_data_o = line_cmp;
            INTR_STATUS: reg_data_o = {12'b0, intr_status_i};
            SCANLINE:    reg_data_o = {12'b0, v_cnt};
            default:     reg_data_o = 16'h0000;
        endcase
    end

endmodule

// File: src/bus_regs.sv
`timescale 1ns/1ps
`include "vid_defines.svh"

module bus_regs import bus_pkg::*; (
    input  logic                      clk,
    input  logic                      reset_i,
    input  logic                      bus_cs_n_i,     // access strobe, active low
    input  logic                      bus_rd_nwr_i,   // 1 = read, 0 = write
    input  logic [3:0]                bus_reg_num_i,
    input  logic                      bus_bytesel_i,  // 0 = even/high byte, 1 = odd/low
    input  logic [7:0]                bus_data_i,
    output logic [7:0]                bus_data_o,
    input  logic                      vgen_sel_i,     // video owns vram this cycle
    output mem_req_t                  req_o,
    output logic [`VID_INTR_BITS-1:0] intr_mask_o,
    output logic [`VID_INTR_BITS-1:0] intr_clear_o,   // one cycle pulse
    input  logic [15:0]               rdata_i,        // vram word
    input  logic                      rdata_valid_i,
    input  logic [15:0]               xr_rdata_i
);

    logic [7:0]  hi_byte;       // even byte waits for the odd one
    logic [15:0] xr_addr;
    logic [15:0] rd_addr;
    logic [15:0] wr_addr;
    logic [15:0] wr_incr;
    logic [15:0] sys_ctrl;      // 3:0 intr mask, 11:8 nibble mask
    logic [15:0] rd_data;       // latched vram read
    logic [15:0] xr_rd_data;    // latched xr read
    logic        xr_load;
    logic        wr_stb;
    logic        rd_stb;
    logic [15:0] wr_word;
    logic [15:0] rd_word;
    reg_num_e    reg_num;

    assign reg_num     = reg_num_e'(bus_reg_num_i);
    assign wr_stb      = ~bus_cs_n_i & ~bus_rd_nwr_i & bus_bytesel_i;    // commit
    assign rd_stb      = ~bus_cs_n_i & bus_rd_nwr_i & bus_bytesel_i;
    assign wr_word     = {hi_byte, bus_data_i};
    assign intr_mask_o = sys_ctrl[`VID_INTR_BITS-1:0];

    // byte read straight from registered state
    always_comb begin
        case (reg_num)
            XR_ADDR:  rd_word = xr_addr;
            XR_DATA:  rd_word = xr_rd_data;
            RD_ADDR:  rd_word = rd_addr;
            WR_ADDR:  rd_word = wr_addr;
            DATA:     rd_word = rd_data;
            WR_INCR:  rd_word = wr_incr;
            SYS_CTRL: rd_word = sys_ctrl;
            default:  rd_word = 16'h0000;
        endcase
    end

    assign bus_data_o = bus_bytesel_i ? rd_word[7:0] : rd_word[15:8];

    always_ff @(posedge clk) begin
        if (~bus_cs_n_i & ~bus_rd_nwr_i & ~bus_bytesel_i) begin
            hi_byte <= bus_data_i;
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            xr_addr      <= '0;
            rd_addr      <= '0;
            wr_addr      <= '0;
            wr_incr      <= 16'h0001;
            sys_ctrl     <= '0;
            rd_data      <= '0;
            xr_rd_data   <= '0;
            xr_load      <= 1'b0;
            req_o        <= '0;
            intr_clear_o <= '0;
        end else begin
            intr_clear_o <= '0;
            req_o.xr_sel <= 1'b0;                       // xr never waits
            xr_load      <= req_o.xr_sel & ~req_o.wr;
            if (xr_load) begin
                xr_rd_data <= xr_rdata_i;
            end
            if (rdata_valid_i) begin
                rd_data <= rdata_i;
            end
            // vram request slips in on a free cycle, then auto increment
            if (req_o.vram_sel && !vgen_sel_i) begin
                req_o.vram_sel <= 1'b0;
                if (req_o.wr) begin
                    wr_addr <= wr_addr + wr_incr;
                end else begin
                    rd_addr <= rd_addr + wr_incr;
                end
            end
            if (wr_stb) begin
                case (reg_num)
                    XR_ADDR: begin
                        xr_addr      <= wr_word;
                        req_o.xr_sel <= 1'b1;            // fetch register for XR_DATA
                        req_o.wr     <= 1'b0;
                        req_o.addr   <= wr_word;
                    end
                    XR_DATA: begin
                        req_o.xr_sel <= 1'b1;
                        req_o.wr     <= 1'b1;
                        req_o.addr   <= xr_addr;
                        req_o.wdata  <= wr_word;
                    end
                    RD_ADDR: begin
                        rd_addr        <= wr_word;
                        req_o.vram_sel <= 1'b1;          // prefetch
                        req_o.wr       <= 1'b0;
                        req_o.addr     <= wr_word;
                    end
                    WR_ADDR:  wr_addr <= wr_word;
                    DATA: begin
                        req_o.vram_sel <= 1'b1;
                        req_o.wr       <= 1'b1;
                        req_o.mask     <= sys_ctrl[11:8];
                        req_o.addr     <= wr_addr;
                        req_o.wdata    <= wr_word;
                    end
                    WR_INCR:  wr_incr <= wr_word;
                    SYS_CTRL: sys_ctrl <= wr_word;
                    INTR_CLR: intr_clear_o <= wr_word[`VID_INTR_BITS-1:0];
                    default: ;
                endcase
            end else if (rd_stb && reg_num == DATA) begin
                req_o.vram_sel <= 1'b1;                  // next word at advanced addr
                req_o.wr       <= 1'b0;
                req_o.addr     <= rd_addr;
            end
        end
    end

endmodule

// File: src/palette_mem.sv
`timescale 1ns/1ps
`include "vid_defines.svh"

module palette_mem (
    input  logic        clk,
    input  logic        wr_i,
    input  logic [7:0]  wr_addr_i,
    input  logic [15:0] wr_data_i,
    input  logic [7:0]  rd_addr_i,
    output logic [15:0] rd_data_o   // 11:0 is r, g, b
);

    logic [15:0] mem [`VID_PAL_DEPTH];

    always_ff @(posedge clk) begin
        if (wr_i) begin
            mem[wr_addr_i] <= wr_data_i;
        end
        rd_data_o <= mem[rd_addr_i];    // read every clock for video
    end

endmodule

// File: src/vram.sv
`timescale 1ns/1ps
`include "vid_defines.svh"

module vram (
    input  logic        clk,
    input  logic        sel_i,
    input  logic        wr_i,
    input  logic [3:0]  mask_i,     // one bit per nibble
    input  logic [11:0] addr_i,
    input  logic [15:0] wdata_i,
    output logic [15:0] rdata_o
);

    logic [15:0] mem [`VID_VRAM_DEPTH];

    always_ff @(posedge clk) begin
        if (sel_i) begin
            if (wr_i) begin
                for (int n = 0; n < 4; n++) begin
                    if (mask_i[n]) begin
                        mem[addr_i][n*4 +: 4] <= wdata_i[n*4 +: 4];
                    end
                end
            end
            rdata_o <= mem[addr_i];     // old word on a write cycle
        end
    end

endmodule

// File: src/video_pkg.sv
package video_pkg;

    // xr memory regions, 1..3 reserved
    typedef enum logic [1:0] {
        PALETTE = 2'd0
    } xr_region_e;

    // video registers in xr space
    typedef enum logic [4:0] {
        DISP_BASE   = 5'd0,
        LINE_CMP    = 5'd1,
        INTR_STATUS = 5'd2,     // read only
        SCANLINE    = 5'd3,     // read only
        INTR_RAISE  = 5'd4      // write only, bits 3:2
    } vreg_e;

    // one pixel clock of display output
    typedef struct packed {
        logic        hsync;
        logic        vsync;
        logic        de;
        logic [11:0] rgb;       // 4 bits each r, g, b
    } pixel_t;

endpackage

// File: src/bus_pkg.sv
package bus_pkg;

    // cpu visible register numbers, 8..15 read as zero
    typedef enum logic [3:0] {
        XR_ADDR  = 4'd0,
        XR_DATA  = 4'd1,
        RD_ADDR  = 4'd2,
        WR_ADDR  = 4'd3,
        DATA     = 4'd4,
        WR_INCR  = 4'd5,
        SYS_CTRL = 4'd6,
        INTR_CLR = 4'd7
    } reg_num_e;

    // xr address seen as a video register number
    typedef struct packed {
        logic       is_mem;
        logic [9:0] spare;
        logic [4:0] reg_num;
    } xr_reg_view_t;

    // same word seen as memory region plus offset
    typedef struct packed {
        logic        is_mem;
        logic        spare;
        logic [1:0]  region;
        logic [11:0] offset;
    } xr_mem_view_t;

    typedef union packed {
        xr_reg_view_t r;
        xr_mem_view_t m;
    } xr_addr_u;

    // cpu side memory request, held until taken
    typedef struct packed {
        logic        vram_sel;
        logic        xr_sel;
        logic        wr;
        logic [3:0]  mask;      // vram nibble enables
        logic [15:0] addr;
        logic [15:0] wdata;
    } mem_req_t;

endpackage

// File: src/vid_defines.svh
`ifndef VID_DEFINES_SVH
`define VID_DEFINES_SVH

// raster in pixel clocks and lines
`define VID_H_VISIBLE     16
`define VID_H_TOTAL       24
`define VID_H_SYNC_START  18    // hsync on counts 18 and 19
`define VID_H_SYNC_END    20
`define VID_V_VISIBLE     8
`define VID_V_TOTAL       12
`define VID_V_SYNC_START  9     // vsync on lines 9 and 10
`define VID_V_SYNC_END    11

// memory depths
`define VID_VRAM_DEPTH    4096  // 16-bit words
`define VID_PAL_DEPTH     256

`define VID_INTR_BITS     4     // vblank, line compare, two software

`endif
